/* design/eth_pkg.sv */
`default_nettype none

// Ethernet-side types shared by the IPv4 transmit path
package eth_pkg;

  typedef logic [47:0] mac_addr_t;

  localparam mac_addr_t MAC_BROADCAST = 48'hffff_ffff_ffff;

  // Answer from the ARP table, valid while ack is high
  typedef struct packed {
    mac_addr_t mac;
    logic      err;  // Entry not found
  } arp_rsp_t;

  // Byte stream towards the MAC layer
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
    mac_addr_t  dst_mac;  // Held for the whole frame
  } mac_tx_t;

endpackage

`default_nettype wire

/* design/ipv4_pkg.sv */
`default_nettype none

// IPv4 header layout and client bundles
package ipv4_pkg;

  typedef logic [31:0] ipv4_t;

  localparam int         IPV4_HDR_LEN   = 20;
  localparam int         IPV4_HDR_WORDS = 10;
  localparam logic [7:0] IPV4_VER_IHL   = 8'h45;  // Version 4, no options
  localparam int         N_CLIENTS      = 2;
  localparam int         PAYLOAD_LEAD   = 3;      // Req reg, client, data reg

  // Header fields in wire order, first byte at the top
  typedef struct packed {
    logic [7:0]  ver_ihl;
    logic [7:0]  qos;
    logic [15:0] length;
    logic [15:0] id;
    logic [15:0] flags_fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] chsum;
    ipv4_t       src_ip;
    ipv4_t       dst_ip;
  } ipv4_hdr_fields_t;

  // Built through fields, shifted out through bytes
  typedef union packed {
    ipv4_hdr_fields_t                  fields;
    logic [0:IPV4_HDR_LEN-1][7:0]      bytes;
  } ipv4_hdr_u;

  typedef struct packed {
    logic        rdy;
    ipv4_t       dst_ip;
    logic [7:0]  proto;
    logic [7:0]  ttl;
    logic [15:0] payload_len;
    logic        broadcast;
    logic [7:0]  dat;
    logic        eof;
  } client_tx_t;

  typedef struct packed {
    logic req;
    logic done;  // Single-cycle pulse
  } client_rsp_t;

endpackage

`default_nettype wire

/* design/ipv4_tx_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_arbiter (
  input  wire logic                                             clk,
  input  wire logic                                             rst,
  input  wire ipv4_pkg::client_tx_t  [ipv4_pkg::N_CLIENTS-1:0] client_tx,
  output      ipv4_pkg::client_rsp_t [ipv4_pkg::N_CLIENTS-1:0] client_rsp,
  output      ipv4_pkg::client_tx_t                             sel_tx,
  input  wire logic                                             req,
  input  wire logic                                             done
);

  typedef enum logic {ARB_IDLE, ARB_GRANT} arb_state_t;

  arb_state_t                              state;
  logic [ipv4_pkg::N_CLIENTS-1:0]          rdy_vec;
  logic [ipv4_pkg::N_CLIENTS-1:0]          cur_rdy;  // Ready vector latched in idle
  logic [$clog2(ipv4_pkg::N_CLIENTS)-1:0]  gnt;

  // A client still seeing its done pulse has not dropped rdy yet
  always_comb begin
    for (int i = 0; i < ipv4_pkg::N_CLIENTS; i++) begin
      rdy_vec[i] = client_tx[i].rdy & ~client_rsp[i].done;
    end
  end

  // Lowest-numbered latched client wins
  always_comb begin
    gnt = '0;
    for (int i = ipv4_pkg::N_CLIENTS - 1; i >= 0; i--) begin
      if (cur_rdy[i]) gnt = i[$clog2(ipv4_pkg::N_CLIENTS)-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ARB_IDLE;
      cur_rdy    <= '0;
      sel_tx.rdy <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          cur_rdy <= rdy_vec;
          if (|rdy_vec) state <= ARB_GRANT;
        end
        ARB_GRANT: begin
          sel_tx <= client_tx[gnt];  // Header fields and payload stream
          if (done) begin
            sel_tx.rdy <= 1'b0;
            cur_rdy    <= '0;
            state      <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // Request and done go back to the granted client only
  always_ff @(posedge clk) begin
    if (rst) begin
      client_rsp <= '0;
    end else begin
      for (int i = 0; i < ipv4_pkg::N_CLIENTS; i++) begin
        client_rsp[i].req  <= (state == ARB_GRANT) && (gnt == i) && req;
        client_rsp[i].done <= (state == ARB_GRANT) && (gnt == i) && done;
      end
    end
  end

endmodule

`default_nettype wire

/* design/ipv4_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_ctrl (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              sel_rdy,
  input  wire logic              broadcast,
  input  wire ipv4_pkg::ipv4_t   dst_ip,
  output      logic              chsum_start,
  input  wire logic              chsum_done,
  output      logic              arp_req,
  output      ipv4_pkg::ipv4_t   arp_ipv4,
  input  wire logic              arp_ack,
  input  wire logic              arp_err,
  output      logic              cnt_en,
  input  wire logic              req_mark,
  input  wire logic              frame_end,
  output      logic              load_hdr,
  output      logic              send,
  output      logic              req,
  output      logic              done,
  output      eth_pkg::mac_addr_t dst_mac,
  input  wire eth_pkg::mac_addr_t arp_mac
);

  typedef enum logic [2:0] {
    S_IDLE, S_CHSUM, S_ARP_REQ, S_ARP_REL, S_SEND, S_FINISH
  } ctrl_state_t;

  ctrl_state_t state;
  logic        arp_err_q;

  // Done register is still high the cycle after a packet, so skip it
  assign load_hdr = (state == S_IDLE) && sel_rdy && !done;
  assign send     = (state == S_SEND);
  assign cnt_en   = (state == S_SEND);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      chsum_start <= 1'b0;
      arp_req     <= 1'b0;
      arp_err_q   <= 1'b0;
      req         <= 1'b0;
      done        <= 1'b0;
    end else begin
      chsum_start <= load_hdr;  // Header register loads on the same edge
      done        <= (state == S_FINISH) ||
                     ((state == S_ARP_REL) && !arp_ack && arp_err_q);
      case (state)
        S_IDLE:    if (load_hdr) state <= S_CHSUM;
        S_CHSUM: begin
          if (chsum_done) begin
            if (broadcast) begin
              state <= S_SEND;
            end else begin
              arp_req <= 1'b1;
              state   <= S_ARP_REQ;
            end
          end
        end
        S_ARP_REQ: begin
          if (arp_ack) begin
            arp_err_q <= arp_err;
            arp_req   <= 1'b0;
            state     <= S_ARP_REL;
          end
        end
        S_ARP_REL: if (!arp_ack) state <= arp_err_q ? S_IDLE : S_SEND;  // Wait for ack low
        S_SEND: begin
          if (req_mark) req <= 1'b1;
          if (frame_end) begin
            req   <= 1'b0;
            state <= S_FINISH;
          end
        end
        S_FINISH:  state <= S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

  // Lookup address and destination MAC
  always_ff @(posedge clk) begin
    if ((state == S_CHSUM) && chsum_done) begin
      arp_ipv4 <= dst_ip;
      dst_mac  <= eth_pkg::MAC_BROADCAST;  // Replaced by the ARP answer for unicast
    end
    if ((state == S_ARP_REQ) && arp_ack) dst_mac <= arp_mac;
  end

endmodule

`default_nettype wire

/* design/ipv4_byte_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_byte_counter (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        en,
  input  wire logic [15:0] payload_len,
  output      logic        hdr_end,
  output      logic        req_mark,
  output      logic        frame_end
);

  logic [16:0] cnt;        // Room for header plus a full 16-bit payload
  logic [16:0] last_byte;

  assign last_byte = {1'b0, payload_len} + 17'(ipv4_pkg::IPV4_HDR_LEN - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (en) begin
      cnt <= cnt + 17'd1;
    end else begin
      cnt <= '0;  // Ready for the next frame
    end
  end

  // Marks are only meaningful while counting
  assign hdr_end   = en && (cnt == 17'(ipv4_pkg::IPV4_HDR_LEN - 1));
  assign req_mark  = en && (cnt == 17'(ipv4_pkg::IPV4_HDR_LEN - 1 - ipv4_pkg::PAYLOAD_LEAD));
  assign frame_end = en && (cnt == last_byte);

endmodule

`default_nettype wire

/* design/ipv4_hdr_checksum.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_hdr_checksum (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                start,
  input  wire ipv4_pkg::ipv4_hdr_u hdr,
  output      logic [15:0]         chsum,
  output      logic                chsum_done
);

  logic [ipv4_pkg::IPV4_HDR_LEN*8-1:0]      shreg;  // Remaining words, next one on top
  logic [18:0]                              sum;    // 16 bits plus carry extension
  logic [$clog2(ipv4_pkg::IPV4_HDR_WORDS+1)-1:0] wcnt;
  logic                                     busy;
  logic [16:0]                              fold1;
  logic [15:0]                              fold2;

  // Carry fold can overflow once more
  assign fold1 = {1'b0, sum[15:0]} + 17'(sum[18:16]);
  assign fold2 = fold1[15:0] + 16'(fold1[16]);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      wcnt       <= '0;
      chsum_done <= 1'b0;
    end else begin
      chsum_done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        wcnt <= 1;  // Word 0 is taken straight from the input
      end else if (busy) begin
        if (wcnt == ipv4_pkg::IPV4_HDR_WORDS) begin
          busy       <= 1'b0;
          chsum_done <= 1'b1;
        end else begin
          wcnt <= wcnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sum   <= {3'b000, hdr.bytes[0], hdr.bytes[1]};
      shreg <= {hdr.bytes[2:ipv4_pkg::IPV4_HDR_LEN-1], 16'h0000};
    end else if (busy && (wcnt != ipv4_pkg::IPV4_HDR_WORDS)) begin
      sum   <= sum + {3'b000, shreg[ipv4_pkg::IPV4_HDR_LEN*8-1 -: 16]};
      shreg <= shreg << 16;
    end
    if (busy && (wcnt == ipv4_pkg::IPV4_HDR_WORDS)) chsum <= ~fold2;  // Eleventh cycle
  end

endmodule

`default_nettype wire

/* design/ipv4_tx_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_serializer (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire ipv4_pkg::client_tx_t sel_tx,
  input  wire ipv4_pkg::ipv4_t      local_ipv4,
  input  wire logic                 load_hdr,
  input  wire logic [15:0]          chsum,
  input  wire logic                 send,
  input  wire logic                 hdr_end,
  input  wire eth_pkg::mac_addr_t   dst_mac,
  output      ipv4_pkg::ipv4_hdr_u  hdr,
  output      eth_pkg::mac_tx_t     mac_tx
);

  ipv4_pkg::ipv4_hdr_u hdr_next;
  ipv4_pkg::ipv4_hdr_u tx_hdr;
  ipv4_pkg::ipv4_hdr_u shreg;
  logic [15:0]         pkt_id;   // Identification, counts packets from zero
  logic                pay_sel;  // Header done, payload on the stream

  always_comb begin
    hdr_next.fields.ver_ihl  = ipv4_pkg::IPV4_VER_IHL;
    hdr_next.fields.qos      = 8'h00;
    hdr_next.fields.length   = 16'(ipv4_pkg::IPV4_HDR_LEN) + sel_tx.payload_len;
    hdr_next.fields.id       = pkt_id;
    hdr_next.fields.flags_fo = 16'h0000;  // No fragmentation
    hdr_next.fields.ttl      = sel_tx.ttl;
    hdr_next.fields.proto    = sel_tx.proto;
    hdr_next.fields.chsum    = 16'h0000;  // Zero while summing
    hdr_next.fields.src_ip   = local_ipv4;
    hdr_next.fields.dst_ip   = sel_tx.dst_ip;
  end

  always_comb begin
    tx_hdr              = hdr;
    tx_hdr.fields.chsum = chsum;
  end

  always_ff @(posedge clk) begin
    if (load_hdr) hdr <= hdr_next;
    if (send) shreg.bytes <= {shreg.bytes[1:ipv4_pkg::IPV4_HDR_LEN-1], 8'h00};
    else      shreg       <= tx_hdr;  // Full header waiting for the first send cycle
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_id  <= '0;
      pay_sel <= 1'b0;
    end else begin
      if (load_hdr) pkt_id <= pkt_id + 16'd1;
      if (!send)        pay_sel <= 1'b0;
      else if (hdr_end) pay_sel <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // MAC stream
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      mac_tx.val <= 1'b0;
      mac_tx.sof <= 1'b0;
      mac_tx.eof <= 1'b0;
    end else begin
      mac_tx.val     <= send;
      mac_tx.sof     <= send && !mac_tx.val;  // First byte of the burst
      mac_tx.eof     <= send && pay_sel && sel_tx.eof;
      mac_tx.dat     <= pay_sel ? sel_tx.dat : shreg.bytes[0];
      mac_tx.dst_mac <= dst_mac;
    end
  end

endmodule

`default_nettype wire

/* design/ipv4_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_top (
  input  wire logic                                             clk,
  input  wire logic                                             rst,
  input  wire ipv4_pkg::ipv4_t                                  local_ipv4,
  input  wire ipv4_pkg::client_tx_t  [ipv4_pkg::N_CLIENTS-1:0] client_tx,
  output      ipv4_pkg::client_rsp_t [ipv4_pkg::N_CLIENTS-1:0] client_rsp,
  output      logic                                             arp_req,
  output      ipv4_pkg::ipv4_t                                  arp_ipv4,
  input  wire logic                                             arp_ack,
  input  wire eth_pkg::arp_rsp_t                                arp_rsp,
  output      eth_pkg::mac_tx_t                                 mac_tx
);

  ipv4_pkg::client_tx_t sel_tx;  // Granted client, registered
  ipv4_pkg::ipv4_hdr_u  hdr;
  eth_pkg::mac_addr_t   dst_mac;
  logic [15:0]          chsum;
  logic                 chsum_start, chsum_done;
  logic                 cnt_en, hdr_end, req_mark, frame_end;
  logic                 load_hdr, send, req, done;

  ipv4_tx_arbiter arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .client_tx  (client_tx),
    .client_rsp (client_rsp),
    .sel_tx     (sel_tx),
    .req        (req),
    .done       (done)
  );

  ipv4_tx_ctrl ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .sel_rdy     (sel_tx.rdy),
    .broadcast   (sel_tx.broadcast),
    .dst_ip      (sel_tx.dst_ip),
    .chsum_start (chsum_start),
    .chsum_done  (chsum_done),
    .arp_req     (arp_req),
    .arp_ipv4    (arp_ipv4),
    .arp_ack     (arp_ack),
    .arp_err     (arp_rsp.err),
    .cnt_en      (cnt_en),
    .req_mark    (req_mark),
    .frame_end   (frame_end),
    .load_hdr    (load_hdr),
    .send        (send),
    .req         (req),
    .done        (done),
    .dst_mac     (dst_mac),
    .arp_mac     (arp_rsp.mac)
  );

  ipv4_byte_counter counter_i (
    .clk         (clk),
    .rst         (rst),
    .en          (cnt_en),
    .payload_len (sel_tx.payload_len),
    .hdr_end     (hdr_end),
    .req_mark    (req_mark),
    .frame_end   (frame_end)
  );

  ipv4_hdr_checksum checksum_i (
    .clk        (clk),
    .rst        (rst),
    .start      (chsum_start),
    .hdr        (hdr),
    .chsum      (chsum),
    .chsum_done (chsum_done)
  );

  ipv4_tx_serializer serializer_i (
    .clk        (clk),
    .rst        (rst),
    .sel_tx     (sel_tx),
    .local_ipv4 (local_ipv4),
    .load_hdr   (load_hdr),
    .chsum      (chsum),
    .send       (send),
    .hdr_end    (hdr_end),
    .dst_mac    (dst_mac),
    .hdr        (hdr),
    .mac_tx     (mac_tx)
  );

endmodule

`default_nettype wire

/* sim/ipv4_tx_props.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_props (
  input wire logic                                             clk,
  input wire logic                                             rst,
  input wire logic                                             arp_req,
  input wire logic                                             arp_ack,
  input wire eth_pkg::mac_tx_t                                 mac_tx,
  input wire ipv4_pkg::client_rsp_t [ipv4_pkg::N_CLIENTS-1:0] client_rsp
);

  logic [ipv4_pkg::N_CLIENTS-1:0] req_vec;

  always_comb begin
    for (int i = 0; i < ipv4_pkg::N_CLIENTS; i++) begin
      req_vec[i] = client_rsp[i].req;
    end
  end

  // Four-phase ARP, request held until acknowledged
  a_arp_hold: assert property (@(posedge clk) disable iff (rst)
    arp_req && !arp_ack |=> arp_req)
    else $error("ARP request dropped before acknowledge");

  a_no_gap: assert property (@(posedge clk) disable iff (rst)
    mac_tx.val && !mac_tx.eof |=> mac_tx.val)  // Frame bytes back to back
    else $error("MAC stream gap inside a frame");

  a_one_req: assert property (@(posedge clk) disable iff (rst)
    $onehot0(req_vec))
    else $error("More than one client request active");

endmodule

bind ipv4_tx_top ipv4_tx_props props_i (
  .clk        (clk),
  .rst        (rst),
  .arp_req    (arp_req),
  .arp_ack    (arp_ack),
  .mac_tx     (mac_tx),
  .client_rsp (client_rsp)
);

`default_nettype wire

/* sim/ipv4_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_tb;

  typedef struct packed {
    ipv4_pkg::ipv4_t dst_ip;
    logic [7:0]      proto;
    logic [7:0]      ttl;
    logic [15:0]     len;
    logic            bcast;
  } pkt_cfg_t;

  localparam ipv4_pkg::ipv4_t LOCAL_IP = 32'hc0a8_0001;

  logic                                             clk;
  logic                                             rst;
  ipv4_pkg::client_tx_t  [ipv4_pkg::N_CLIENTS-1:0] client_tx;
  ipv4_pkg::client_rsp_t [ipv4_pkg::N_CLIENTS-1:0] client_rsp;
  logic                                             arp_req;
  ipv4_pkg::ipv4_t                                  arp_ipv4;
  logic                                             arp_ack;
  eth_pkg::arp_rsp_t                                arp_rsp;
  eth_pkg::mac_tx_t                                 mac_tx;

  // Cases read from file
  string             case_name[$];
  int                case_mask[$];
  pkt_cfg_t          case_c0[$];
  pkt_cfg_t          case_c1[$];
  eth_pkg::arp_rsp_t case_arp[$];
  int                case_delay[$];
  logic [15:0]       case_cs0[$];
  logic [15:0]       case_cs1[$];

  // State of the running case
  pkt_cfg_t          cur_cfg [0:1];
  eth_pkg::arp_rsp_t cur_arp;
  int                cur_delay;
  logic [7:0]        pay [0:1][0:255];
  int                pay_idx [0:1];
  bit                streaming [0:1];
  bit                go [0:1];
  int                seed = 19;
  logic [15:0]       next_id = 16'd0;
  int                limit_cycles = 0;

  // Monitor results
  logic [7:0]         rx_bytes[$];
  int                 rx_len[$];
  eth_pkg::mac_addr_t rx_mac[$];
  ipv4_pkg::ipv4_t    rx_arp_ip[$];  // Lookup address at each ARP request
  int                 cur_len = 0;
  eth_pkg::mac_addr_t cur_mac;
  bit                 in_frame = 0;
  int                 done_cnt [0:1];
  logic               arp_req_q = 1'b0;

  ipv4_tx_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .local_ipv4 (LOCAL_IP),
    .client_tx  (client_tx),
    .client_rsp (client_rsp),
    .arp_req    (arp_req),
    .arp_ipv4   (arp_ipv4),
    .arp_ack    (arp_ack),
    .arp_rsp    (arp_rsp),
    .mac_tx     (mac_tx)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Error: %s expected %02h actual %02h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_chsum(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    if (act !== exp) begin
      $display("Error: %s expected %04h actual %04h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_mac(input string name, input eth_pkg::mac_addr_t exp,
                           input eth_pkg::mac_addr_t act);
    if (act !== exp) begin
      $display("Error: %s expected %012h actual %012h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_ip(input string name, input ipv4_pkg::ipv4_t exp,
                          input ipv4_pkg::ipv4_t act);
    if (act !== exp) begin
      $display("Error: %s expected %08h actual %08h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error: %s expected %0d actual %0d", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Models and monitor
  ////////////////////////////////////////////////////////////////////////////
  // Clients raise rdy with fields, stream from the first req and drop rdy on done
  initial begin : client_model
    ipv4_pkg::client_rsp_t [ipv4_pkg::N_CLIENTS-1:0] rsp_s;
    client_tx = '0;
    forever begin
      @(negedge clk);
      rsp_s = client_rsp;
      @(posedge clk);
      #5;
      for (int i = 0; i < ipv4_pkg::N_CLIENTS; i++) begin
        if (rsp_s[i].done) begin
          client_tx[i].rdy = 1'b0;
          client_tx[i].eof = 1'b0;
          streaming[i]     = 1'b0;
          pay_idx[i]       = 0;
        end else if ((rsp_s[i].req || streaming[i]) && pay_idx[i] < int'(cur_cfg[i].len)) begin
          client_tx[i].dat = pay[i][pay_idx[i]];
          client_tx[i].eof = (pay_idx[i] == int'(cur_cfg[i].len) - 1);
          pay_idx[i]++;
          streaming[i] = 1'b1;
        end else begin
          client_tx[i].eof = 1'b0;
        end
        if (go[i]) begin
          client_tx[i].dst_ip      = cur_cfg[i].dst_ip;
          client_tx[i].proto       = cur_cfg[i].proto;
          client_tx[i].ttl         = cur_cfg[i].ttl;
          client_tx[i].payload_len = cur_cfg[i].len;
          client_tx[i].broadcast   = cur_cfg[i].bcast;
          client_tx[i].rdy         = 1'b1;
          go[i]                    = 1'b0;
        end
      end
    end
  end

  initial begin : arp_model
    arp_ack = 1'b0;
    arp_rsp = '0;
    forever begin
      @(negedge clk);
      if (arp_req && !arp_ack) begin
        repeat (cur_delay) @(negedge clk);
        @(posedge clk);
        #5;
        arp_rsp = cur_arp;
        arp_ack = 1'b1;
        @(negedge clk);
        while (arp_req) @(negedge clk);
        @(posedge clk);
        #5;
        arp_ack = 1'b0;  // Phase 4
      end
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      for (int i = 0; i < ipv4_pkg::N_CLIENTS; i++) begin
        if (client_rsp[i].done) done_cnt[i]++;
      end
      if (arp_req && !arp_req_q) rx_arp_ip.push_back(arp_ipv4);
      if (mac_tx.val) begin
        if (in_frame == mac_tx.sof) stop_run("Start of frame flag out of place on MAC stream");
        if (!in_frame) cur_mac = mac_tx.dst_mac;
        else if (mac_tx.dst_mac !== cur_mac) stop_run("Destination MAC changed inside a frame");
        in_frame = 1'b1;
        rx_bytes.push_back(mac_tx.dat);
        cur_len++;
        if (mac_tx.eof) begin
          rx_len.push_back(cur_len);
          rx_mac.push_back(cur_mac);
          in_frame = 1'b0;
          cur_len  = 0;
        end
      end else if (in_frame) begin
        stop_run("MAC stream went idle inside a frame");
      end
    end
    arp_req_q = arp_req;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Case sequence
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_case(input int c);
    string              nm;
    int                 mask;
    int                 f;
    int                 off;
    int                 exp_arp;
    logic [159:0]       hv;
    logic [15:0]        cs;
    eth_pkg::mac_addr_t exp_mac;
    pkt_cfg_t           pc;
    nm          = case_name[c];
    mask        = case_mask[c];
    cur_cfg[0]  = case_c0[c];
    cur_cfg[1]  = case_c1[c];
    cur_arp     = case_arp[c];
    cur_delay   = case_delay[c];
    for (int i = 0; i < 2; i++) begin
      if (mask[i]) begin
        for (int k = 0; k < int'(cur_cfg[i].len); k++) pay[i][k] = 8'($random(seed));
      end
    end
    rx_bytes.delete();
    rx_len.delete();
    rx_mac.delete();
    rx_arp_ip.delete();
    done_cnt[0] = 0;
    done_cnt[1] = 0;
    go[0]       = mask[0];
    go[1]       = mask[1];
    while ((mask[0] && done_cnt[0] == 0) || (mask[1] && done_cnt[1] == 0)) @(negedge clk);
    repeat (6) @(negedge clk);  // Room for a stray done or frame

    f       = 0;
    off     = 0;
    exp_arp = 0;
    for (int i = 0; i < 2; i++) begin
      check_count($sformatf("%s done pulses of client %0d", nm, i), mask[i], done_cnt[i]);
      if (mask[i]) begin
        pc = cur_cfg[i];
        cs = (i == 0) ? case_cs0[c] : case_cs1[c];
        if (!pc.bcast) begin
          if (exp_arp >= rx_arp_ip.size()) begin
            stop_run($sformatf("%s ARP request of client %0d missing", nm, i));
          end
          check_ip($sformatf("%s arp_ipv4", nm), pc.dst_ip, rx_arp_ip[exp_arp]);
          exp_arp++;
        end
        if (pc.bcast || !cur_arp.err) begin
          if (f >= rx_len.size()) stop_run($sformatf("%s frame of client %0d missing", nm, i));
          check_count($sformatf("%s frame length", nm), 20 + int'(pc.len), rx_len[f]);
          exp_mac = pc.bcast ? eth_pkg::MAC_BROADCAST : cur_arp.mac;
          check_mac($sformatf("%s dst_mac", nm), exp_mac, rx_mac[f]);
          hv = {8'h45, 8'h00, 16'd20 + pc.len, next_id, 16'h0000, pc.ttl, pc.proto, cs,
                LOCAL_IP, pc.dst_ip};
          for (int k = 0; k < 20; k++) begin
            if (k == 10) begin
              check_chsum($sformatf("%s checksum", nm), cs, {rx_bytes[off+10], rx_bytes[off+11]});
            end else if (k != 11) begin
              check_byte($sformatf("%s hdr[%0d]", nm, k), hv[159-8*k -: 8], rx_bytes[off+k]);
            end
          end
          for (int k = 0; k < int'(pc.len); k++) begin
            check_byte($sformatf("%s payload[%0d]", nm, k), pay[i][k], rx_bytes[off+20+k]);
          end
          off += 20 + int'(pc.len);
          f++;
        end
        next_id = next_id + 16'd1;  // Every granted packet takes an id
      end
    end
    check_count($sformatf("%s frames", nm), f, rx_len.size());
    check_count($sformatf("%s ARP requests", nm), exp_arp, rx_arp_ip.size());
  endtask

  initial begin : main
    int          fd;
    int          n;
    int          total;
    string       line;
    string       nm;
    int          mask, ln0, ln1, bc0, bc1, aerr, adly;
    logic [31:0] dst0, dst1;
    logic [7:0]  pr0, pr1, tt0, tt1;
    logic [47:0] amac;
    logic [15:0] cs0, cs1;
    rst   = 1'b1;
    total = 0;
    fd    = $fopen("sim/ipv4_tx_cases.txt", "r");
    if (fd == 0) stop_run("Cannot open sim/ipv4_tx_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (n > 0 && line.len() > 4 && line.getc(0) != 8'h23) begin  // Skip column notes
        n = $sscanf(line, "%s %d %h %h %h %d %d %h %h %h %d %d %h %d %d %h %h",
                    nm, mask, dst0, pr0, tt0, ln0, bc0, dst1, pr1, tt1, ln1, bc1,
                    amac, aerr, adly, cs0, cs1);
        if (n != 17) stop_run("Malformed line in the cases file");
        case_name.push_back(nm);
        case_mask.push_back(mask);
        case_c0.push_back('{dst_ip: dst0, proto: pr0, ttl: tt0, len: ln0[15:0], bcast: bc0[0]});
        case_c1.push_back('{dst_ip: dst1, proto: pr1, ttl: tt1, len: ln1[15:0], bcast: bc1[0]});
        case_arp.push_back('{mac: amac, err: aerr[0]});
        case_delay.push_back(adly);
        case_cs0.push_back(cs0);
        case_cs1.push_back(cs1);
        total += 200 + 20 * ((mask[0] ? ln0 : 0) + (mask[1] ? ln1 : 0));
      end
    end
    $fclose(fd);
    limit_cycles = total + 10;
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;
    for (int c = 0; c < case_name.size(); c++) run_case(c);
    $display("=== PASS ===");
    $finish;
  end

  // Budget of cycles grows with case count and payload size
  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles", limit_cycles);
    $display("=== FAIL ===");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* sim/ipv4_tx_cases.txt */
# name mask | client 0: dst_ip proto ttl len bcast | client 1: dst_ip proto ttl len bcast
# arp_mac arp_err arp_delay | chsum0 chsum1  (mask, len, bcast, err, delay decimal, rest hex)
unicast0 1 c0a80002 11 40 40 0 00000000 00 00 0 0 021122334455 0 3 f95d 0000
bcast1 2 00000000 00 00 0 0 ffffffff 11 40 5 1 000000000000 0 0 0000 ba2a
arperr0 1 0a000005 01 80 4 0 00000000 00 00 0 0 000000000000 1 2 7035 0000
both 3 c0a80002 06 40 12 0 c0a80003 11 20 3 0 02aabbccddee 0 5 f981 197e
unicast1 2 00000000 00 00 0 0 0a000001 11 40 1 0 020102030405 0 0 0000 b029

/* ipv4_tx.f */
design/eth_pkg.sv
design/ipv4_pkg.sv
design/ipv4_tx_arbiter.sv
design/ipv4_tx_ctrl.sv
design/ipv4_byte_counter.sv
design/ipv4_hdr_checksum.sv
design/ipv4_tx_serializer.sv
design/ipv4_tx_top.sv
sim/ipv4_tx_props.sv
sim/ipv4_tx_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module ipv4_tx_tb \
		-f ipv4_tx.f -o ipv4_tx_sim

run: compile
	./obj_dir/ipv4_tx_sim | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
